// File: verilog/core_pkg.sv
package core_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Data and address width
    localparam int unsigned XLEN = 32;

    // Boot address counts words, two zero bits appended at reset
    localparam int unsigned BOOT_ADDR_W = XLEN - 2;

    ////////////////////
    // PC increments
    ////////////////////

    // Step after a 16-bit compressed word
    localparam logic [XLEN-1:0] PC_INC_C = 32'd2;

    // Step after a full 32-bit word
    localparam logic [XLEN-1:0] PC_INC_I = 32'd4;

    ////////////////////
    // PC source
    ////////////////////

    // What a stage asks of the PC controller
    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_JUMP   = 2'b01,
        PC_BRANCH = 2'b10
    } pc_source_t;

    ////////////////////
    // IF/ID bundle
    ////////////////////

    // Contents of the IF/ID register, 65 bits
    typedef struct packed {
        // Address the word was fetched from
        logic [XLEN-1:0] pc;
        // Raw fetched word
        logic [XLEN-1:0] instr;
        // Cleared for a bubble
        logic            valid;
    } if_id_t;

endpackage

// File: verilog/instr_pkg.sv
package instr_pkg;

    ////////////////////
    // Opcodes
    ////////////////////

    // Full-width JAL
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    // Low bits of any full-width word
    localparam logic [1:0] OP_FULL = 2'b11;

    // Compressed quadrant 1 and its jump funct3 codes
    localparam logic [1:0] C_OP_C1  = 2'b01;
    localparam logic [2:0] C_F3_J   = 3'b101;
    localparam logic [2:0] C_F3_JAL = 3'b001;

    // Reserved illegal encoding
    localparam logic [31:0] ILLEGAL_INSTR = 32'h0000_0000;

    ////////////////////
    // Formats
    ////////////////////

    // J-type, offset bits scattered as the ISA places them
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // CJ format of C.J and C.JAL
    typedef struct packed {
        logic [2:0] funct3;
        logic       imm_11;
        logic       imm_4;
        logic [1:0] imm_9_8;
        logic       imm_10;
        logic       imm_6;
        logic       imm_7;
        logic [2:0] imm_3_1;
        logic       imm_5;
        logic [1:0] op;
    } cj_type_t;

    // Two halfwords, only the low one decoded
    typedef struct packed {
        cj_type_t hi;
        cj_type_t lo;
    } cj_pair_t;

    // One fetched word, read either way
    typedef union packed {
        j_type_t  j;
        cj_pair_t c;
    } instr_word_u;

endpackage

// File: verilog/pc_controller.sv
`timescale 1ns/100ps

module pc_controller import core_pkg::*; (
    // Current fetch address
    input  logic [XLEN-1:0] curr_pc_i,
    input  logic            is_compressed_if_i,

    // ID stage jump request
    input  logic            valid_id_i,
    input  logic [XLEN-1:0] jump_target_id_i,
    input  pc_source_t      pc_source_id_i,

    // EX stage branch request
    input  logic            valid_ex_i,
    input  logic [XLEN-1:0] branch_target_ex_i,
    input  logic            branch_decision_ex_i,
    input  pc_source_t      pc_source_ex_i,

    // Traps and return
    input  logic            trap_id_i,
    input  logic            trap_ex_i,
    input  logic            is_mret_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,

    // Selected address and flush request
    output logic [XLEN-1:0] next_pc_o,
    output logic            redirect_o
);

    ////////////////////
    // Request decode
    ////////////////////

    logic            take_trap;
    logic            take_mret;
    logic            take_branch;
    logic            take_jump;
    logic [XLEN-1:0] seq_pc;

    // Either stage may raise a trap
    assign take_trap = trap_id_i | trap_ex_i;

    assign take_mret = is_mret_i;

    // Branch needs valid, branch type and taken decision
    assign take_branch = valid_ex_i
                       & (pc_source_ex_i == PC_BRANCH)
                       & branch_decision_ex_i;

    assign take_jump = valid_id_i & (pc_source_id_i == PC_JUMP);

    // Sequential step by fetched word size
    assign seq_pc = curr_pc_i + (is_compressed_if_i ? PC_INC_C : PC_INC_I);

    ////////////////////
    // Priority mux
    ////////////////////

    always_comb begin
        if (take_trap) begin
            next_pc_o = mtvec_i;
        end else if (take_mret) begin
            next_pc_o = mepc_i;
        end else if (take_branch) begin
            // Older instruction wins over ID jump
            next_pc_o = branch_target_ex_i;
        end else if (take_jump) begin
            next_pc_o = jump_target_id_i;
        end else begin
            next_pc_o = seq_pc;
        end
    end

    // Any non-sequential winner flushes the wrong-path fetch
    assign redirect_o = take_trap | take_mret | take_branch | take_jump;

endmodule

// File: verilog/if_stage.sv
`timescale 1ns/100ps

module if_stage import core_pkg::*, instr_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [BOOT_ADDR_W-1:0] boot_addr_i,

    // Instruction memory, combinational read
    input  logic [XLEN-1:0]        imem_rdata_i,
    output logic [XLEN-1:0]        imem_addr_o,

    // Back-pressure
    input  logic                   stall_if_i,

    // Traps and return
    input  logic                   trap_id_i,
    input  logic                   trap_ex_i,
    input  logic                   is_mret_i,
    input  logic [XLEN-1:0]        mtvec_i,
    input  logic [XLEN-1:0]        mepc_i,

    // Jump and branch requests
    input  logic                   valid_id_i,
    input  logic                   valid_ex_i,
    input  logic [XLEN-1:0]        jump_target_id_i,
    input  logic [XLEN-1:0]        branch_target_ex_i,
    input  logic                   branch_decision_ex_i,
    input  pc_source_t             pc_source_id_i,
    input  pc_source_t             pc_source_ex_i,

    // Towards IF/ID
    output if_id_t                 fetch_o,
    output logic                   redirect_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic            is_compressed;
    instr_word_u     fetched_w;

    ////////////////////
    // Fetch
    ////////////////////

    assign imem_addr_o = pc_q;
    assign fetched_w   = imem_rdata_i;

    // Compressed unless low op bits are 11
    assign is_compressed = (fetched_w.c.lo.op != OP_FULL);

    // PC register, boot address word-aligned
    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= {boot_addr_i, 2'b00};
        end else if (!stall_if_i) begin
            pc_q <= pc_d;
        end
    end

    ////////////////////
    // Next PC
    ////////////////////

    pc_controller pc_controller_i (
        .curr_pc_i            ( pc_q                 ),
        .is_compressed_if_i   ( is_compressed        ),
        .valid_id_i           ( valid_id_i           ),
        .jump_target_id_i     ( jump_target_id_i     ),
        .pc_source_id_i       ( pc_source_id_i       ),
        .valid_ex_i           ( valid_ex_i           ),
        .branch_target_ex_i   ( branch_target_ex_i   ),
        .branch_decision_ex_i ( branch_decision_ex_i ),
        .pc_source_ex_i       ( pc_source_ex_i       ),
        .trap_id_i            ( trap_id_i            ),
        .trap_ex_i            ( trap_ex_i            ),
        .is_mret_i            ( is_mret_i            ),
        .mtvec_i              ( mtvec_i              ),
        .mepc_i               ( mepc_i               ),
        .next_pc_o            ( pc_d                 ),
        .redirect_o           ( redirect_o           )
    );

    ////////////////////
    // Bundle
    ////////////////////

    // Fetch itself never invalidates, flush happens in IF/ID
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = imem_rdata_i;
    assign fetch_o.valid = 1'b1;

endmodule

// File: verilog/if_id_reg.sv
`timescale 1ns/100ps

module if_id_reg import core_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,

    // Hold contents
    input  logic   stall_i,
    // Turn the incoming slot into a bubble
    input  logic   flush_i,

    // Fetch bundle in
    input  if_id_t fetch_i,

    // Registered bundle out
    output if_id_t id_o
);

    ////////////////////
    // Pipeline register
    ////////////////////

    if_id_t id_q;

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            // Empty pipeline after reset
            id_q <= '0;
        end else if (!stall_i) begin
            id_q.pc    <= fetch_i.pc;
            id_q.instr <= fetch_i.instr;
            // Wrong-path fetch kept visible but marked invalid
            id_q.valid <= fetch_i.valid & ~flush_i;
        end
    end

    assign id_o = id_q;

endmodule

// File: verilog/jump_decoder.sv
`timescale 1ns/100ps

module jump_decoder import core_pkg::*, instr_pkg::*; (
    // IF/ID contents
    input  if_id_t          id_i,

    // Requests towards the PC controller
    output logic            valid_id_o,
    output pc_source_t      pc_source_id_o,
    output logic [XLEN-1:0] jump_target_id_o,
    output logic            trap_id_o
);

    instr_word_u     word;
    logic            is_compressed;
    logic            is_jal;
    logic            is_cj;
    logic [XLEN-1:0] j_offset;
    logic [XLEN-1:0] cj_offset;
    logic [XLEN-1:0] offset;

    assign word = id_i.instr;

    ////////////////////
    // Decode
    ////////////////////

    assign is_compressed = (word.c.lo.op != OP_FULL);

    // Full JAL
    assign is_jal = ~is_compressed & (word.j.opcode == OPC_JAL);

    // C.J or C.JAL in quadrant 1
    assign is_cj = (word.c.lo.op == C_OP_C1)
                 & ((word.c.lo.funct3 == C_F3_J) | (word.c.lo.funct3 == C_F3_JAL));

    ////////////////////
    // Offsets
    ////////////////////

    // J-type, 21-bit signed, bit 0 zero
    assign j_offset = {{11{word.j.imm_20}},
                       word.j.imm_20,
                       word.j.imm_19_12,
                       word.j.imm_11,
                       word.j.imm_10_1,
                       1'b0};

    // CJ, 12-bit signed, bits rebuilt from scrambled field
    assign cj_offset = {{20{word.c.lo.imm_11}},
                        word.c.lo.imm_11,
                        word.c.lo.imm_10,
                        word.c.lo.imm_9_8,
                        word.c.lo.imm_7,
                        word.c.lo.imm_6,
                        word.c.lo.imm_5,
                        word.c.lo.imm_4,
                        word.c.lo.imm_3_1,
                        1'b0};

    assign offset = is_compressed ? cj_offset : j_offset;

    // PC relative target
    assign jump_target_id_o = id_i.pc + offset;

    ////////////////////
    // Outputs
    ////////////////////

    assign valid_id_o = id_i.valid;

    // Bubbles never redirect
    assign pc_source_id_o = (id_i.valid & (is_jal | is_cj)) ? PC_JUMP : PC_SEQ;

    // All-zero word is the reserved illegal encoding
    assign trap_id_o = id_i.valid & (id_i.instr == ILLEGAL_INSTR);

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/100ps

module fetch_top import core_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [BOOT_ADDR_W-1:0] boot_addr_i,

    // Instruction memory
    input  logic [XLEN-1:0]        imem_rdata_i,
    output logic [XLEN-1:0]        imem_addr_o,

    // Back-pressure for IF and IF/ID
    input  logic                   stall_i,

    // Later stages, seen as plain ports
    input  logic                   trap_ex_i,
    input  logic                   is_mret_i,
    input  logic [XLEN-1:0]        mtvec_i,
    input  logic [XLEN-1:0]        mepc_i,
    input  logic                   valid_ex_i,
    input  logic [XLEN-1:0]        branch_target_ex_i,
    input  logic                   branch_decision_ex_i,
    input  pc_source_t             pc_source_ex_i,

    // IF/ID contents
    output if_id_t                 id_o
);

    if_id_t          fetch;
    logic            redirect;
    logic            valid_id;
    pc_source_t      pc_source_id;
    logic [XLEN-1:0] jump_target_id;
    logic            trap_id;

    ////////////////////
    // Fetch
    ////////////////////

    if_stage if_stage_i (
        .clk_i                ( clk_i                ),
        .rst_n_i              ( rst_n_i              ),
        .boot_addr_i          ( boot_addr_i          ),
        .imem_rdata_i         ( imem_rdata_i         ),
        .imem_addr_o          ( imem_addr_o          ),
        .stall_if_i           ( stall_i              ),
        .trap_id_i            ( trap_id              ),
        .trap_ex_i            ( trap_ex_i            ),
        .is_mret_i            ( is_mret_i            ),
        .mtvec_i              ( mtvec_i              ),
        .mepc_i               ( mepc_i               ),
        .valid_id_i           ( valid_id             ),
        .valid_ex_i           ( valid_ex_i           ),
        .jump_target_id_i     ( jump_target_id       ),
        .branch_target_ex_i   ( branch_target_ex_i   ),
        .branch_decision_ex_i ( branch_decision_ex_i ),
        .pc_source_id_i       ( pc_source_id         ),
        .pc_source_ex_i       ( pc_source_ex_i       ),
        .fetch_o              ( fetch                ),
        .redirect_o           ( redirect             )
    );

    ////////////////////
    // IF/ID
    ////////////////////

    if_id_reg if_id_reg_i (
        .clk_i   ( clk_i    ),
        .rst_n_i ( rst_n_i  ),
        .stall_i ( stall_i  ),
        .flush_i ( redirect ),
        .fetch_i ( fetch    ),
        .id_o    ( id_o     )
    );

    ////////////////////
    // ID jumps
    ////////////////////

    jump_decoder jump_decoder_i (
        .id_i             ( id_o           ),
        .valid_id_o       ( valid_id       ),
        .pc_source_id_o   ( pc_source_id   ),
        .jump_target_id_o ( jump_target_id ),
        .trap_id_o        ( trap_id        )
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset held over the first 3 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: sim/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb import core_pkg::*; ();

    ////////////////////
    // Types and state
    ////////////////////

    // One cycle of stimulus plus what IF and IF/ID should show
    typedef struct packed {
        logic        stall;
        logic        valid_ex;
        pc_source_t  src_ex;
        logic        decision_ex;
        logic        trap_ex;
        logic        mret;
        logic [31:0] exp_addr;
        if_id_t      exp_id;
    } row_t;

    localparam logic [29:0] BOOT_WORD = 30'h40;
    localparam logic [31:0] BOOT_PC   = 32'h100;

    logic            clk;
    logic            rst_n;
    logic [29:0]     boot_addr;
    logic [31:0]     imem_rdata;
    logic [31:0]     imem_addr;
    logic            stall;
    logic            trap_ex;
    logic            is_mret;
    logic [31:0]     mtvec;
    logic [31:0]     mepc;
    logic            valid_ex;
    logic [31:0]     branch_target;
    logic            branch_decision;
    pc_source_t      pc_source_ex;
    if_id_t          id;

    // Program halfwords by address
    logic [15:0]     prog_mem [logic [31:0]];
    logic            mem_ready = 1'b0;

    row_t            rows [$];
    int              row_grp [$];
    string           grp_name [8];
    logic [31:0]     lcg_state;
    logic [31:0]     tvec;
    logic [31:0]     epc;
    logic [31:0]     br_target;
    int              pass_cnt = 0;
    int              fail_cnt = 0;
    int              cycle_cnt = 0;
    int              cycle_limit = 0;

    ////////////////////
    // Clock, DUT, memory
    ////////////////////

    tb_clock_gen clock_gen_i (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    fetch_top dut_i (
        .clk_i                ( clk             ),
        .rst_n_i              ( rst_n           ),
        .boot_addr_i          ( boot_addr       ),
        .imem_rdata_i         ( imem_rdata      ),
        .imem_addr_o          ( imem_addr       ),
        .stall_i              ( stall           ),
        .trap_ex_i            ( trap_ex         ),
        .is_mret_i            ( is_mret         ),
        .mtvec_i              ( mtvec           ),
        .mepc_i               ( mepc            ),
        .valid_ex_i           ( valid_ex        ),
        .branch_target_ex_i   ( branch_target   ),
        .branch_decision_ex_i ( branch_decision ),
        .pc_source_ex_i       ( pc_source_ex    ),
        .id_o                 ( id              )
    );

    // Fill halfword of a full ADDI-type word that is never zero nor a jump
    function automatic logic [15:0] fill_half(input logic [31:0] a);
        logic [15:0] f;
        f = a[31:16] ^ a[15:0];
        return {f[15:7] ^ f[8:0], 7'b0010011};
    endfunction

    function automatic logic [15:0] read_half(input logic [31:0] a);
        if (prog_mem.exists(a)) begin
            return prog_mem[a];
        end
        return fill_half(a);
    endfunction

    // Little endian word at any halfword address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {read_half(a + 32'd2), read_half(a)};
    endfunction

    // Combinational read that re-evaluates once the preload is done
    assign imem_rdata = mem_ready ? mem_word(imem_addr) : 32'h0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////
    // Table helpers
    ////////////////////

    // Idle stimulus with id_o carrying the word at pc
    function automatic row_t expect_row(input logic [31:0] addr, input logic [31:0] pc,
                                        input logic v);
        row_t r;
        r = '0;
        r.src_ex = PC_SEQ;
        r.exp_addr = addr;
        r.exp_id.pc = pc;
        r.exp_id.instr = mem_word(pc);
        r.exp_id.valid = v;
        return r;
    endfunction

    task automatic push_row(input row_t r, input int grp);
        rows.push_back(r);
        row_grp.push_back(grp);
    endtask

    task automatic preload_program();
        prog_mem[32'h100] = 16'h0001;   // C.NOP
        prog_mem[32'h102] = 16'h0013;   // Full-width NOP
        prog_mem[32'h104] = 16'h0000;
        prog_mem[32'h106] = 16'h0001;
        prog_mem[32'h108] = 16'h006f;   // JAL x0, +16
        prog_mem[32'h10a] = 16'h0100;
        prog_mem[32'h10c] = 16'h0013;   // Wrong-path slot behind JAL
        prog_mem[32'h10e] = 16'h0000;
        prog_mem[32'h118] = 16'ha021;   // C.J +8
        prog_mem[32'h11a] = 16'h0001;
        prog_mem[32'h11c] = 16'h0001;
        prog_mem[32'h120] = 16'h0001;
        // Illegal all-zero word
        prog_mem[32'h122] = 16'h0000;
        prog_mem[32'h124] = 16'h0000;
        // C.JAL +4 at the return address
        prog_mem[epc] = 16'h2011;
    endtask

    task automatic apply_row(input row_t r);
        stall           = r.stall;
        valid_ex        = r.valid_ex;
        pc_source_ex    = r.src_ex;
        branch_decision = r.decision_ex;
        trap_ex         = r.trap_ex;
        is_mret         = r.mret;
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic compare_addr(input int row, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: row %0d imem_addr_o %h, expected %h", $time, row, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic compare_id(input int row, input if_id_t got, input if_id_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: row %0d id_o pc %h instr %h valid %b, expected %h %h %b",
                     $time, row, got.pc, got.instr, got.valid,
                     exp.pc, exp.instr, exp.valid);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    ////////////////////
    // Watchdog
    ////////////////////

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        row_t r;
        int   grp_fail_start;

        boot_addr       = BOOT_WORD;
        stall           = 1'b0;
        trap_ex         = 1'b0;
        is_mret         = 1'b0;
        valid_ex        = 1'b0;
        branch_decision = 1'b0;
        pc_source_ex    = PC_SEQ;

        // Word-aligned vectors in separate regions
        lcg_state = 32'h6a2c0958;
        lcg_state = lcg_next(lcg_state);
        tvec = {4'h1, lcg_state[27:2], 2'b00};
        lcg_state = lcg_next(lcg_state);
        epc = {4'h2, lcg_state[27:2], 2'b00};
        lcg_state = lcg_next(lcg_state);
        br_target = {4'h3, lcg_state[27:2], 2'b00};
        mtvec         = tvec;
        mepc          = epc;
        branch_target = br_target;

        preload_program();
        mem_ready = 1'b1;

        grp_name[0] = "reset and sequential fetch";
        grp_name[1] = "ID jumps";
        grp_name[2] = "zero word trap";
        grp_name[3] = "untaken branches";
        grp_name[4] = "stall";
        grp_name[5] = "EX trap";
        grp_name[6] = "MRET";
        grp_name[7] = "branch over ID jump";

        // Reset state with IF/ID cleared
        r = expect_row(BOOT_PC, 32'h0, 1'b0);
        r.exp_id.instr = '0;
        push_row(r, 0);
        // Steps of 2 and 4 by word size
        push_row(expect_row(32'h102, 32'h100, 1'b1), 0);
        push_row(expect_row(32'h106, 32'h102, 1'b1), 0);
        push_row(expect_row(32'h108, 32'h106, 1'b1), 0);

        // JAL in ID followed by C.J in ID
        push_row(expect_row(32'h10c, 32'h108, 1'b1), 1);
        push_row(expect_row(32'h118, 32'h10c, 1'b0), 1);
        push_row(expect_row(32'h11a, 32'h118, 1'b1), 1);
        push_row(expect_row(32'h120, 32'h11a, 1'b0), 1);

        // Zero word fetched at 0x122 traps from ID
        push_row(expect_row(32'h122, 32'h120, 1'b1), 2);
        push_row(expect_row(32'h124, 32'h122, 1'b1), 2);
        push_row(expect_row(tvec, 32'h124, 1'b0), 2);

        // Each of these drops one branch condition
        r = expect_row(tvec + 32'd4, tvec, 1'b1);
        r.valid_ex = 1'b1;
        r.src_ex = PC_BRANCH;
        push_row(r, 3);
        r = expect_row(tvec + 32'd8, tvec + 32'd4, 1'b1);
        r.src_ex = PC_BRANCH;
        r.decision_ex = 1'b1;
        push_row(r, 3);
        r = expect_row(tvec + 32'd12, tvec + 32'd8, 1'b1);
        r.valid_ex = 1'b1;
        r.src_ex = PC_JUMP;
        r.decision_ex = 1'b1;
        push_row(r, 3);
        push_row(expect_row(tvec + 32'd16, tvec + 32'd12, 1'b1), 3);

        // Two stalled cycles before release
        r = expect_row(tvec + 32'd20, tvec + 32'd16, 1'b1);
        r.stall = 1'b1;
        push_row(r, 4);
        push_row(r, 4);
        push_row(expect_row(tvec + 32'd20, tvec + 32'd16, 1'b1), 4);
        push_row(expect_row(tvec + 32'd24, tvec + 32'd20, 1'b1), 4);

        r = expect_row(tvec + 32'd28, tvec + 32'd24, 1'b1);
        r.trap_ex = 1'b1;
        push_row(r, 5);
        push_row(expect_row(tvec, tvec + 32'd28, 1'b0), 5);
        push_row(expect_row(tvec + 32'd4, tvec, 1'b1), 5);

        r = expect_row(tvec + 32'd8, tvec + 32'd4, 1'b1);
        r.mret = 1'b1;
        push_row(r, 6);
        push_row(expect_row(epc, tvec + 32'd8, 1'b0), 6);

        // C.JAL in ID while EX branch is taken
        r = expect_row(epc + 32'd2, epc, 1'b1);
        r.valid_ex = 1'b1;
        r.src_ex = PC_BRANCH;
        r.decision_ex = 1'b1;
        push_row(r, 7);
        push_row(expect_row(br_target, epc + 32'd2, 1'b0), 7);
        push_row(expect_row(br_target + 32'd4, br_target, 1'b1), 7);

        cycle_limit = 2 * rows.size() + 20;

        wait (rst_n);
        #1;
        grp_fail_start = 0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            // Sample well clear of both edges
            #2;
            compare_addr(i, imem_addr, rows[i].exp_addr);
            compare_id(i, id, rows[i].exp_id);
            if (i == rows.size() - 1 || row_grp[i + 1] != row_grp[i]) begin
                $display("%s: %0d mismatches", grp_name[row_grp[i]],
                         fail_cnt - grp_fail_start);
                grp_fail_start = fail_cnt;
            end
            @(posedge clk);
            #1;
        end

        $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/core_pkg.sv
verilog/instr_pkg.sv
verilog/pc_controller.sv
verilog/if_stage.sv
verilog/if_id_reg.sv
verilog/jump_decoder.sv
verilog/fetch_top.sv
sim/tb_clock_gen.sv
sim/fetch_tb.sv

// File: Makefile
TOP = fetch_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
